//--- Makefile
TOP := tb_axi_slave

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f files.f -o V$(TOP)

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- files.f
rtl/axi_pkg.sv
rtl/slave_pkg.sv
rtl/burst_if.sv
rtl/ram_if.sv
rtl/axi_burst_ctx.sv
rtl/byte_ram.sv
rtl/axi_write_ctrl.sv
rtl/axi_read_ctrl.sv
rtl/axi_slave_top.sv
verif/tb_axi_slave.sv

//--- rtl/axi_burst_ctx.sv
`timescale 1ns/100ps

module axi_burst_ctx #(
        parameter int MEM_BYTES = slave_pkg::MEM_BYTES_DEF
) (
        input logic  clk,
        input logic  resetn,
        burst_if.ctx bus
);

        localparam int AW = axi_pkg::ADDR_W;
        localparam logic [AW:0] MEM_LIMIT = (AW+1)'(MEM_BYTES);

        logic [AW-3:0]             word_q;        // current word index
        axi_pkg::burst_t           burst_q;
        logic [axi_pkg::LEN_W:0]   left_q;        // beats still to go
        logic [axi_pkg::ID_W-1:0]  id_q;
        axi_pkg::resp_t            resp_q;

        logic [AW:0]               first_byte;
        logic [AW:0]               span;
        logic [AW:0]               end_byte;
        axi_pkg::resp_t            resp_d;

        ////////////////////////////////////////
        // response decision on the request

        assign first_byte = {1'b0, bus.addr[AW-1:2], 2'b00};
        assign end_byte   = first_byte + span;    // last byte touched

        always_comb begin
                if (bus.burst == axi_pkg::BURST_FIXED) begin
                        span = (AW+1)'(3);
                end else begin
                        span = {{(AW-axi_pkg::LEN_W-1){1'b0}}, bus.len, 2'b11};  // 4*(len+1)-1
                end
        end

        always_comb begin
                if (bus.size != axi_pkg::SIZE_WORD) begin
                        resp_d = axi_pkg::RESP_SLVERR;
                end else if (end_byte >= MEM_LIMIT) begin
                        resp_d = axi_pkg::RESP_DECERR;
                end else begin
                        resp_d = axi_pkg::RESP_OKAY;
                end
        end

        ////////////////////////////////////////
        // burst state

        always_ff @(posedge clk or negedge resetn) begin
                if (!resetn) begin
                        left_q <= '0;
                        id_q   <= '0;
                        resp_q <= axi_pkg::RESP_OKAY;
                end else if (bus.start) begin
                        left_q <= {1'b0, bus.len} + 1'b1;
                        id_q   <= bus.req_id;
                        resp_q <= resp_d;
                end else if (bus.step) begin
                        left_q <= left_q - 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (bus.start) begin
                        word_q  <= bus.addr[AW-1:2];  // low two bits dropped
                        burst_q <= bus.burst;
                end else if (bus.step && burst_q != axi_pkg::BURST_FIXED) begin
                        word_q <= word_q + 1'b1;
                end
        end

        assign bus.beat_addr = {word_q, 2'b00};
        assign bus.last      = (left_q == {{axi_pkg::LEN_W{1'b0}}, 1'b1});
        assign bus.id        = id_q;
        assign bus.resp      = resp_q;

        // a step only lands inside a started burst
        a_step_in_burst : assert property (@(posedge clk) disable iff (!resetn)
                bus.step |-> left_q != '0)
                else $error("burst step without a started burst");

endmodule

//--- rtl/axi_pkg.sv
package axi_pkg;

        ////////////////////////////////////////
        // channel field widths

        localparam int ADDR_W = 32;
        localparam int DATA_W = 32;
        localparam int STRB_W = DATA_W / 8;        // one strobe per byte lane
        localparam int ID_W   = 4;
        localparam int LEN_W  = 4;                 // beats minus one
        localparam int SIZE_W = 3;

        localparam logic [SIZE_W-1:0] SIZE_WORD = 3'd2;   // 4 bytes per beat

        ////////////////////////////////////////
        // burst and response codes

        typedef enum logic [1:0] {
                BURST_FIXED = 2'd0,
                BURST_INCR  = 2'd1                 // wrap and reserved fall here too
        } burst_t;

        typedef enum logic [1:0] {
                RESP_OKAY   = 2'd0,
                RESP_SLVERR = 2'd2,                // size not supported
                RESP_DECERR = 2'd3                 // no memory at that address
        } resp_t;

endpackage

//--- rtl/axi_read_ctrl.sv
`timescale 1ns/100ps

module axi_read_ctrl (
        input  logic                        clk,
        input  logic                        resetn,
        input  logic                        arvalid,
        output logic                        arready,
        input  logic [axi_pkg::ID_W-1:0]    arid,
        input  logic [axi_pkg::ADDR_W-1:0]  araddr,
        input  logic [axi_pkg::LEN_W-1:0]   arlen,
        input  logic [axi_pkg::SIZE_W-1:0]  arsize,
        input  logic [1:0]                  arburst,
        output logic                        rvalid,
        input  logic                        rready,
        output logic [axi_pkg::ID_W-1:0]    rid,
        output logic [axi_pkg::DATA_W-1:0]  rdata,
        output logic [1:0]                  rresp,
        output logic                        rlast,
        burst_if.ctrl                       ctx,
        ram_if.reader                       ram
);

        slave_pkg::rd_state_t state;
        slave_pkg::rd_state_t state_nxt;
        logic                 r_fire;
        logic                 resp_ok;

        assign r_fire  = rvalid && rready;
        assign resp_ok = (ctx.resp == axi_pkg::RESP_OKAY);

        always_ff @(posedge clk or negedge resetn) begin
                if (!resetn) begin
                        state <= slave_pkg::R_IDLE;
                end else begin
                        state <= state_nxt;
                end
        end

        always_comb begin
                state_nxt = state;
                unique case (state)
                        slave_pkg::R_IDLE: if (arvalid) state_nxt = slave_pkg::R_ADDR;
                        slave_pkg::R_ADDR: begin
                                state_nxt = arvalid ? slave_pkg::R_FETCH : slave_pkg::R_IDLE;
                        end
                        slave_pkg::R_FETCH: state_nxt = slave_pkg::R_DATA;
                        slave_pkg::R_DATA: begin
                                if (r_fire) begin
                                        state_nxt = ctx.last ? slave_pkg::R_IDLE : slave_pkg::R_FETCH;
                                end
                        end
                endcase
        end

        ////////////////////////////////////////
        // channel outputs

        assign arready = (state == slave_pkg::R_ADDR);
        assign rvalid  = (state == slave_pkg::R_DATA);
        assign rdata   = (rvalid && resp_ok) ? ram.rdata : '0;   // zero on error beats
        assign rid     = rvalid ? ctx.id : '0;
        assign rresp   = rvalid ? ctx.resp : axi_pkg::RESP_OKAY;
        assign rlast   = rvalid && ctx.last;

        assign ctx.start  = arvalid && arready;
        assign ctx.step   = r_fire;
        assign ctx.addr   = araddr;
        assign ctx.len    = arlen;
        assign ctx.size   = arsize;
        assign ctx.burst  = axi_pkg::burst_t'(arburst);
        assign ctx.req_id = arid;

        // one read per beat, none outside memory
        assign ram.re    = (state == slave_pkg::R_FETCH) && resp_ok;
        assign ram.raddr = ctx.beat_addr[axi_pkg::ADDR_W-1:2];

        a_rbeat_hold : assert property (@(posedge clk) disable iff (!resetn)
                rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
                else $error("read beat changed before rready");

endmodule

//--- rtl/axi_slave_top.sv
`timescale 1ns/100ps

module axi_slave_top #(
        parameter int MEM_BYTES = slave_pkg::MEM_BYTES_DEF
) (
        input  logic                        clk,
        input  logic                        resetn,

        ////////////////////////////////////////
        // write address, data and response
        input  logic                        awvalid,
        output logic                        awready,
        input  logic [axi_pkg::ID_W-1:0]    awid,
        input  logic [axi_pkg::ADDR_W-1:0]  awaddr,
        input  logic [axi_pkg::LEN_W-1:0]   awlen,
        input  logic [axi_pkg::SIZE_W-1:0]  awsize,
        input  logic [1:0]                  awburst,
        input  logic                        wvalid,
        output logic                        wready,
        input  logic [axi_pkg::DATA_W-1:0]  wdata,
        input  logic [axi_pkg::STRB_W-1:0]  wstrb,
        input  logic                        wlast,
        output logic                        bvalid,
        input  logic                        bready,
        output logic [axi_pkg::ID_W-1:0]    bid,
        output logic [1:0]                  bresp,

        ////////////////////////////////////////
        // read address and data
        input  logic                        arvalid,
        output logic                        arready,
        input  logic [axi_pkg::ID_W-1:0]    arid,
        input  logic [axi_pkg::ADDR_W-1:0]  araddr,
        input  logic [axi_pkg::LEN_W-1:0]   arlen,
        input  logic [axi_pkg::SIZE_W-1:0]  arsize,
        input  logic [1:0]                  arburst,
        output logic                        rvalid,
        input  logic                        rready,
        output logic [axi_pkg::ID_W-1:0]    rid,
        output logic [axi_pkg::DATA_W-1:0]  rdata,
        output logic [1:0]                  rresp,
        output logic                        rlast
);

        burst_if wr_bus ();                       // write controller context
        burst_if rd_bus ();                       // read controller context
        ram_if   mem_bus ();                      // shared by both controllers

        axi_burst_ctx #(.MEM_BYTES(MEM_BYTES)) u_wr_ctx (
                .clk    (clk),
                .resetn (resetn),
                .bus    (wr_bus)
        );

        axi_burst_ctx #(.MEM_BYTES(MEM_BYTES)) u_rd_ctx (
                .clk    (clk),
                .resetn (resetn),
                .bus    (rd_bus)
        );

        byte_ram #(.MEM_BYTES(MEM_BYTES)) u_ram (
                .clk  (clk),
                .port (mem_bus)
        );

        // channel ports match by name
        axi_write_ctrl u_wr (.*, .ctx(wr_bus), .ram(mem_bus));
        axi_read_ctrl  u_rd (.*, .ctx(rd_bus), .ram(mem_bus));

endmodule

//--- rtl/axi_write_ctrl.sv
`timescale 1ns/100ps

module axi_write_ctrl (
        input  logic                        clk,
        input  logic                        resetn,
        input  logic                        awvalid,
        output logic                        awready,
        input  logic [axi_pkg::ID_W-1:0]    awid,
        input  logic [axi_pkg::ADDR_W-1:0]  awaddr,
        input  logic [axi_pkg::LEN_W-1:0]   awlen,
        input  logic [axi_pkg::SIZE_W-1:0]  awsize,
        input  logic [1:0]                  awburst,
        input  logic                        wvalid,
        output logic                        wready,
        input  logic [axi_pkg::DATA_W-1:0]  wdata,
        input  logic [axi_pkg::STRB_W-1:0]  wstrb,
        input  logic                        wlast,
        output logic                        bvalid,
        input  logic                        bready,
        output logic [axi_pkg::ID_W-1:0]    bid,
        output logic [1:0]                  bresp,
        burst_if.ctrl                       ctx,
        ram_if.writer                       ram
);

        slave_pkg::wr_state_t state;
        slave_pkg::wr_state_t state_nxt;
        logic                 w_fire;

        assign w_fire = wvalid && wready;

        always_ff @(posedge clk or negedge resetn) begin
                if (!resetn) begin
                        state <= slave_pkg::W_IDLE;
                end else begin
                        state <= state_nxt;
                end
        end

        always_comb begin
                state_nxt = state;
                unique case (state)
                        slave_pkg::W_IDLE: if (awvalid) state_nxt = slave_pkg::W_ADDR;
                        slave_pkg::W_ADDR: begin
                                state_nxt = awvalid ? slave_pkg::W_DATA : slave_pkg::W_IDLE;
                        end
                        slave_pkg::W_DATA: if (w_fire && ctx.last) state_nxt = slave_pkg::W_RESP;
                        slave_pkg::W_RESP: if (bready) state_nxt = slave_pkg::W_IDLE;
                endcase
        end

        ////////////////////////////////////////
        // channel outputs

        assign awready = (state == slave_pkg::W_ADDR);
        assign wready  = (state == slave_pkg::W_DATA);
        assign bvalid  = (state == slave_pkg::W_RESP);
        assign bid     = bvalid ? ctx.id : '0;
        assign bresp   = bvalid ? ctx.resp : axi_pkg::RESP_OKAY;

        // burst context, captured on the aw handshake
        assign ctx.start  = awvalid && awready;
        assign ctx.step   = w_fire;
        assign ctx.addr   = awaddr;
        assign ctx.len    = awlen;
        assign ctx.size   = awsize;
        assign ctx.burst  = axi_pkg::burst_t'(awburst);
        assign ctx.req_id = awid;

        // memory written only on good bursts
        assign ram.we    = w_fire && (ctx.resp == axi_pkg::RESP_OKAY);
        assign ram.waddr = ctx.beat_addr[axi_pkg::ADDR_W-1:2];
        assign ram.wdata = wdata;
        assign ram.wstrb = wstrb;

        a_bvalid_hold : assert property (@(posedge clk) disable iff (!resetn)
                bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
                else $error("write response dropped before bready");

        a_wlast_count : assert property (@(posedge clk) disable iff (!resetn)
                w_fire |-> wlast == ctx.last)
                else $error("wlast disagrees with awlen beat count");

endmodule

//--- rtl/burst_if.sv
`timescale 1ns/100ps

interface burst_if;
        logic                         start;      // request fields valid, one cycle
        logic                         step;       // one beat done
        logic [axi_pkg::ADDR_W-1:0]   addr;
        logic [axi_pkg::LEN_W-1:0]    len;
        logic [axi_pkg::SIZE_W-1:0]   size;
        axi_pkg::burst_t              burst;
        logic [axi_pkg::ID_W-1:0]     req_id;

        logic [axi_pkg::ADDR_W-1:0]   beat_addr;  // byte address of current beat
        logic                         last;
        logic [axi_pkg::ID_W-1:0]     id;
        axi_pkg::resp_t               resp;

        modport ctx (input start, step, addr, len, size, burst, req_id,
                     output beat_addr, last, id, resp);
        modport ctrl (output start, step, addr, len, size, burst, req_id,
                      input beat_addr, last, id, resp);
endinterface

//--- rtl/byte_ram.sv
`timescale 1ns/100ps

module byte_ram #(
        parameter int MEM_BYTES = slave_pkg::MEM_BYTES_DEF
) (
        input logic  clk,
        ram_if.ram   port
);

        localparam int WORDS = MEM_BYTES / 4;
        localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
        localparam int SW    = axi_pkg::STRB_W;

        logic [axi_pkg::DATA_W-1:0] mem [WORDS] = '{default: {SW{slave_pkg::INIT_BYTE}}};

        // byte lanes written in place
        always_ff @(posedge clk) begin
                if (port.we) begin
                        for (int b = 0; b < SW; b++) begin
                                if (port.wstrb[b]) begin
                                        mem[port.waddr[IDX_W-1:0]][8*b +: 8] <= port.wdata[8*b +: 8];
                                end
                        end
                end
        end

        // registered read, held between reads
        always_ff @(posedge clk) begin
                if (port.re) begin
                        port.rdata <= mem[port.raddr[IDX_W-1:0]];
                end
        end

endmodule

//--- rtl/ram_if.sv
`timescale 1ns/100ps

interface ram_if;
        // write port
        logic                         we;
        logic [axi_pkg::ADDR_W-3:0]   waddr;      // word index
        logic [axi_pkg::DATA_W-1:0]   wdata;
        logic [axi_pkg::STRB_W-1:0]   wstrb;

        // read port
        logic                         re;
        logic [axi_pkg::ADDR_W-3:0]   raddr;      // word index
        logic [axi_pkg::DATA_W-1:0]   rdata;      // one cycle after re

        modport writer (output we, waddr, wdata, wstrb);
        modport reader (output re, raddr, input rdata);
        modport ram (input we, waddr, wdata, wstrb, re, raddr,
                     output rdata);
endinterface

//--- rtl/slave_pkg.sv
package slave_pkg;

        localparam int MEM_BYTES_DEF = 128;
        localparam logic [7:0] INIT_BYTE = 8'h0c;  // power-up value of each byte

        typedef enum logic [1:0] {
                W_IDLE,
                W_ADDR,                            // awready pulse
                W_DATA,                            // wready level
                W_RESP                             // bvalid until bready
        } wr_state_t;

        typedef enum logic [1:0] {
                R_IDLE,
                R_ADDR,                            // arready pulse
                R_FETCH,                           // ram read issued
                R_DATA                             // beat on the bus
        } rd_state_t;

endpackage

//--- verif/tb_axi_slave.sv
`timescale 1ns/100ps

module tb_axi_slave;

        localparam int MEM_BYTES = slave_pkg::MEM_BYTES_DEF;
        localparam int N_BURSTS  = 21;            // bursts issued by the main sequence

        logic        clk = 1'b0;
        logic        resetn;
        logic        awvalid, wvalid, wlast, bready, arvalid, rready;
        logic [3:0]  awid, awlen, arid, arlen, wstrb;
        logic [31:0] awaddr, araddr, wdata;
        logic [2:0]  awsize, arsize;
        logic [1:0]  awburst, arburst;
        logic        awready, wready, bvalid, arready, rvalid, rlast;
        logic [3:0]  bid, rid;
        logic [1:0]  bresp, rresp;
        logic [31:0] rdata;

        logic [7:0]  model [MEM_BYTES];           // expected memory bytes
        logic [31:0] lfsr = 32'h3e011ed1;

        axi_slave_top #(.MEM_BYTES(MEM_BYTES)) uut (.*);

        always #5 clk = ~clk;

        ////////////////////////////////////////
        // failure reporting

        task automatic stop_on_error(input string msg);
                $display("%s", msg);
                $display("Test failed");
                $fatal(1, "simulation stopped on error");
        endtask

        task automatic report_mismatch(input string name, input logic [31:0] exp,
                                       input logic [31:0] act);
                stop_on_error($sformatf("Mismatch %s expected 0x%08h actual 0x%08h",
                                        name, exp, act));
        endtask

        ////////////////////////////////////////
        // random source and reference model

        function automatic logic [31:0] next_lfsr(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
        endfunction

        task automatic take_bits(input int n, output logic [31:0] v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        lfsr = next_lfsr(lfsr);
                        v = {v[30:0], lfsr[0]};   // one step per bit
                end
        endtask

        function automatic logic [1:0] expect_resp(input logic [31:0] addr, input logic [3:0] len,
                                                   input logic [2:0] size, input logic [1:0] burst);
                longint last_byte;
                last_byte = longint'(addr) / 4 * 4;
                if (burst == 2'd0) begin
                        last_byte = last_byte + 3;
                end else begin
                        last_byte = last_byte + 4 * (longint'(len) + 1) - 1;
                end
                if (size != axi_pkg::SIZE_WORD) begin
                        return axi_pkg::RESP_SLVERR;
                end else if (last_byte >= MEM_BYTES) begin
                        return axi_pkg::RESP_DECERR;
                end
                return axi_pkg::RESP_OKAY;
        endfunction

        function automatic logic [31:0] model_word(input int widx);
                return {model[4*widx+3], model[4*widx+2], model[4*widx+1], model[4*widx]};
        endfunction

        task automatic wait_cycles(input int n);
                repeat (n) begin
                        @(posedge clk);
                        #1;                       // inputs move just after the edge
                end
        endtask

        ////////////////////////////////////////
        // write and read bursts

        task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                                   input logic [3:0] len, input logic [2:0] size,
                                   input logic [1:0] burst, input bit stall);
                logic [1:0]  exp_resp;
                logic [31:0] data;
                logic [31:0] strb;
                logic [31:0] gap;
                int          widx;
                exp_resp = expect_resp(addr, len, size, burst);
                awvalid = 1'b1;
                awid    = id;
                awaddr  = addr;
                awlen   = len;
                awsize  = size;
                awburst = burst;
                while (!awready) wait_cycles(1);
                wait_cycles(1);                   // address taken here
                awvalid = 1'b0;
                for (int beat = 0; beat <= int'(len); beat++) begin
                        take_bits(32, data);
                        take_bits(4, strb);
                        if (stall) begin
                                take_bits(2, gap);
                                wvalid = 1'b0;
                                wait_cycles(int'(gap));
                        end
                        wvalid = 1'b1;
                        wdata  = data;
                        wstrb  = strb[3:0];
                        wlast  = (beat == int'(len));
                        while (!wready) wait_cycles(1);
                        wait_cycles(1);
                        if (exp_resp == axi_pkg::RESP_OKAY) begin
                                widx = int'(addr[31:2]) + ((burst == 2'd0) ? 0 : beat);
                                for (int b = 0; b < 4; b++) begin
                                        if (strb[b]) model[4*widx+b] = data[8*b +: 8];
                                end
                        end
                end
                wvalid = 1'b0;
                wlast  = 1'b0;
                while (!bvalid) wait_cycles(1);
                if (stall) begin
                        take_bits(2, gap);
                        wait_cycles(int'(gap) + 1);   // bready held low meanwhile
                end
                assert (bid == id) else report_mismatch("bid", 32'(id), 32'(bid));
                assert (bresp == exp_resp)
                        else report_mismatch("bresp", 32'(exp_resp), 32'(bresp));
                bready = 1'b1;
                wait_cycles(1);
                bready = 1'b0;
        endtask

        task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                                  input logic [3:0] len, input logic [2:0] size,
                                  input logic [1:0] burst, input bit stall);
                logic [1:0]  exp_resp;
                logic [31:0] exp_data;
                logic [31:0] gap;
                int          widx;
                exp_resp = expect_resp(addr, len, size, burst);
                arvalid = 1'b1;
                arid    = id;
                araddr  = addr;
                arlen   = len;
                arsize  = size;
                arburst = burst;
                while (!arready) wait_cycles(1);
                wait_cycles(1);
                arvalid = 1'b0;
                for (int beat = 0; beat <= int'(len); beat++) begin
                        while (!rvalid) wait_cycles(1);
                        if (stall) begin
                                take_bits(2, gap);
                                wait_cycles(int'(gap) + 1);
                        end
                        widx = int'(addr[31:2]) + ((burst == 2'd0) ? 0 : beat);
                        exp_data = (exp_resp == axi_pkg::RESP_OKAY) ? model_word(widx) : '0;
                        assert (rdata == exp_data) else report_mismatch("rdata", exp_data, rdata);
                        assert (rid == id) else report_mismatch("rid", 32'(id), 32'(rid));
                        assert (rresp == exp_resp)
                                else report_mismatch("rresp", 32'(exp_resp), 32'(rresp));
                        assert (rlast == (beat == int'(len)))
                                else report_mismatch("rlast", 32'(beat == int'(len)), 32'(rlast));
                        rready = 1'b1;
                        wait_cycles(1);
                        rready = 1'b0;
                end
        endtask

        task automatic random_incr_pair(input bit stall);
                logic [31:0] r;
                logic [3:0]  len;
                logic [3:0]  id;
                logic [31:0] addr;
                int          words;
                take_bits(4, r);
                len   = r[3:0];
                words = MEM_BYTES / 4 - int'(len);   // burst stays inside memory
                take_bits(8, r);
                addr  = 32'((int'(r[7:0]) % words) * 4);
                take_bits(2, r);
                addr  = addr | {30'd0, r[1:0]};      // low bits must be ignored
                take_bits(4, r);
                id    = r[3:0];
                write_burst(id, addr, len, axi_pkg::SIZE_WORD, axi_pkg::BURST_INCR, stall);
                read_burst(~id, addr, len, axi_pkg::SIZE_WORD, axi_pkg::BURST_INCR, stall);
        endtask

        task automatic check_reset_outputs();
                assert (!awready) else report_mismatch("awready", 32'd0, 32'(awready));
                assert (!wready) else report_mismatch("wready", 32'd0, 32'(wready));
                assert (!arready) else report_mismatch("arready", 32'd0, 32'(arready));
                assert (!bvalid) else report_mismatch("bvalid", 32'd0, 32'(bvalid));
                assert (!rvalid) else report_mismatch("rvalid", 32'd0, 32'(rvalid));
                assert (!rlast) else report_mismatch("rlast", 32'd0, 32'(rlast));
                assert (bid == '0) else report_mismatch("bid", 32'd0, 32'(bid));
                assert (bresp == '0) else report_mismatch("bresp", 32'd0, 32'(bresp));
                assert (rid == '0) else report_mismatch("rid", 32'd0, 32'(rid));
                assert (rresp == '0) else report_mismatch("rresp", 32'd0, 32'(rresp));
                assert (rdata == '0) else report_mismatch("rdata", 32'd0, rdata);
        endtask

        ////////////////////////////////////////
        // protocol checks

        a_b_hold : assert property (@(posedge clk) disable iff (!resetn)
                bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
                else stop_on_error("write response changed before bready");

        a_r_hold : assert property (@(posedge clk) disable iff (!resetn)
                rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid)
                        && $stable(rresp) && $stable(rlast))
                else stop_on_error("read beat changed before rready");

        a_aw_pulse : assert property (@(posedge clk) disable iff (!resetn)
                awready |=> !awready)
                else stop_on_error("awready stayed high for more than one cycle");

        a_ar_pulse : assert property (@(posedge clk) disable iff (!resetn)
                arready |=> !arready)
                else stop_on_error("arready stayed high for more than one cycle");

        initial begin
                repeat (N_BURSTS * 40 + 200) @(posedge clk);
                stop_on_error("watchdog expired before the bursts completed");
        end

        ////////////////////////////////////////
        // main sequence

        initial begin
                resetn  = 1'b0;
                awvalid = 1'b0;
                awid    = '0;
                awaddr  = '0;
                awlen   = '0;
                awsize  = '0;
                awburst = '0;
                wvalid  = 1'b0;
                wdata   = '0;
                wstrb   = '0;
                wlast   = 1'b0;
                bready  = 1'b0;
                arvalid = 1'b0;
                arid    = '0;
                araddr  = '0;
                arlen   = '0;
                arsize  = '0;
                arburst = '0;
                rready  = 1'b0;
                for (int i = 0; i < MEM_BYTES; i++) model[i] = slave_pkg::INIT_BYTE;
                repeat (8) @(posedge clk);
                #1;
                resetn = 1'b1;
                wait_cycles(2);
                check_reset_outputs();
                read_burst(4'h1, 32'h7c, 4'd0, axi_pkg::SIZE_WORD, axi_pkg::BURST_INCR, 1'b0);

                repeat (4) random_incr_pair(1'b0);

                // fixed bursts overlay one word
                write_burst(4'h5, 32'h40, 4'd3, axi_pkg::SIZE_WORD, axi_pkg::BURST_FIXED, 1'b0);
                read_burst(4'h6, 32'h42, 4'd2, axi_pkg::SIZE_WORD, axi_pkg::BURST_FIXED, 1'b0);

                // past the end of memory
                write_burst(4'h7, 32'(MEM_BYTES - 8), 4'd3, axi_pkg::SIZE_WORD,
                            axi_pkg::BURST_INCR, 1'b0);
                read_burst(4'h8, 32'(MEM_BYTES - 8), 4'd3, axi_pkg::SIZE_WORD,
                           axi_pkg::BURST_INCR, 1'b0);
                read_burst(4'h9, 32'(MEM_BYTES - 8), 4'd1, axi_pkg::SIZE_WORD,
                           axi_pkg::BURST_INCR, 1'b0);

                // narrow sizes
                write_burst(4'ha, 32'h20, 4'd1, 3'd1, axi_pkg::BURST_INCR, 1'b0);
                read_burst(4'hb, 32'h20, 4'd1, 3'd0, axi_pkg::BURST_INCR, 1'b0);
                read_burst(4'hc, 32'h20, 4'd1, axi_pkg::SIZE_WORD, axi_pkg::BURST_INCR, 1'b0);

                repeat (2) random_incr_pair(1'b1);  // with back-pressure

                $display("Test passed");
                $finish;
        end

endmodule
